//--- common/pet_video_pkg.sv
`default_nettype none

package pet_video_pkg;

    // a data byte on the video bus or in a crtc register.
    typedef logic [7:0]  byte_t;

    // character cell counts, horizontal and vertical.
    typedef logic [7:0]  char_cnt_t;

    // scanline within a character row.
    typedef logic [4:0]  row_addr_t;

    // crtc refresh memory address.
    typedef logic [13:0] mem_addr_t;

    // shared video ram / character rom bus address.
    typedef logic [13:0] bus_addr_t;

    // crtc register index, as held in the address register.
    typedef logic [4:0]  reg_idx_t;

    // position inside the 16 clock character cycle.
    typedef logic [3:0]  phase_t;

    // owner of the video bus in the current phase.
    typedef enum logic [1:0] {
        SLOT_IDLE = 2'd0,
        SLOT_VRAM = 2'd1,
        SLOT_VROM = 2'd2
    } fetch_slot_e;

    // implemented crtc register indexes (6845 numbering).
    localparam reg_idx_t R_HTOTAL     = 5'd0;
    localparam reg_idx_t R_HDISP      = 5'd1;
    localparam reg_idx_t R_HSYNC_POS  = 5'd2;
    localparam reg_idx_t R_SYNC_WIDTH = 5'd3;
    localparam reg_idx_t R_VTOTAL     = 5'd4;
    localparam reg_idx_t R_VDISP      = 5'd6;
    localparam reg_idx_t R_VSYNC_POS  = 5'd7;
    localparam reg_idx_t R_MAX_SCAN   = 5'd9;
    localparam reg_idx_t R_START_HI   = 5'd12;
    localparam reg_idx_t R_START_LO   = 5'd13;

endpackage

`default_nettype wire

//--- crtc/crtc_regs.sv
`default_nettype none
`timescale 1ns/1ps

module crtc_regs
    import pet_video_pkg::*;
(
    input  wire logic      clk16_i,
    input  wire logic      rst_n_i,
    input  wire logic      cs_i,
    input  wire logic      rw_n_i,
    input  wire logic      rs_i,
    input  wire byte_t     data_i,
    output char_cnt_t      htotal_o,
    output char_cnt_t      hdisp_o,
    output char_cnt_t      hsync_pos_o,
    output char_cnt_t      vtotal_o,
    output char_cnt_t      vdisp_o,
    output char_cnt_t      vsync_pos_o,
    output logic [3:0]     hsync_width_o,
    output logic [3:0]     vsync_width_o,
    output row_addr_t      max_scan_o,
    output mem_addr_t      start_addr_o
);

    reg_idx_t   addr_q;
    byte_t      sync_width_q;
    logic [5:0] start_hi_q;
    byte_t      start_lo_q;
    logic       wr_en;

    assign wr_en = cs_i && !rw_n_i;

    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_q       <= '0;
            // 40x25 text screen, 8 scanlines per character row.
            htotal_o     <= 8'd49;
            hdisp_o      <= 8'd40;
            hsync_pos_o  <= 8'd41;
            sync_width_q <= 8'h28;
            vtotal_o     <= 8'd31;
            vdisp_o      <= 8'd25;
            vsync_pos_o  <= 8'd28;
            max_scan_o   <= 5'd7;
            start_hi_q   <= '0;
            start_lo_q   <= '0;
        end else if (wr_en) begin
            if (!rs_i) begin
                addr_q <= data_i[4:0];
            end else begin
                // unimplemented indexes fall through and are dropped.
                case (addr_q)
                    R_HTOTAL:     htotal_o     <= data_i;
                    R_HDISP:      hdisp_o      <= data_i;
                    R_HSYNC_POS:  hsync_pos_o  <= data_i;
                    R_SYNC_WIDTH: sync_width_q <= data_i;
                    R_VTOTAL:     vtotal_o     <= data_i;
                    R_VDISP:      vdisp_o      <= data_i;
                    R_VSYNC_POS:  vsync_pos_o  <= data_i;
                    R_MAX_SCAN:   max_scan_o   <= data_i[4:0];
                    R_START_HI:   start_hi_q   <= data_i[5:0];
                    R_START_LO:   start_lo_q   <= data_i;
                    default: ;
                endcase
            end
        end
    end

    // low nibble is horizontal width in characters, high nibble is scanlines.
    assign hsync_width_o = sync_width_q[3:0];
    assign vsync_width_o = sync_width_q[7:4];

    assign start_addr_o = {start_hi_q, start_lo_q};

endmodule

`default_nettype wire

//--- crtc/crtc_timing.sv
`default_nettype none
`timescale 1ns/1ps

module crtc_timing
    import pet_video_pkg::*;
(
    input  wire logic       clk16_i,
    input  wire logic       rst_n_i,
    input  wire logic       char_en_i,
    input  wire char_cnt_t  htotal_i,
    input  wire char_cnt_t  hdisp_i,
    input  wire char_cnt_t  hsync_pos_i,
    input  wire char_cnt_t  vtotal_i,
    input  wire char_cnt_t  vdisp_i,
    input  wire char_cnt_t  vsync_pos_i,
    input  wire logic [3:0] hsync_width_i,
    input  wire logic [3:0] vsync_width_i,
    input  wire row_addr_t  max_scan_i,
    input  wire mem_addr_t  start_addr_i,
    output mem_addr_t       ma_o,
    output row_addr_t       ra_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            de_o
);

    char_cnt_t  col_q;
    char_cnt_t  row_q;
    char_cnt_t  col_next;
    char_cnt_t  row_next;
    row_addr_t  scan_next;
    mem_addr_t  row_base_q;
    mem_addr_t  row_base_next;
    mem_addr_t  ma_next;
    logic [3:0] vs_left_q;
    logic [3:0] vs_left_next;
    logic       line_end;
    logic       row_end;
    logic       frame_end;
    logic [8:0] hs_end;
    logic       hsync_now;

    // compare with >= so a total written below the count still wraps.
    assign line_end  = (col_q >= htotal_i);
    assign row_end   = line_end && (ra_o >= max_scan_i);
    assign frame_end = row_end && (row_q >= vtotal_i);

    // row_base tracks start + row * hdisp, so ma is row_base + column.
    always_comb begin
        col_next      = line_end ? '0 : col_q + 8'd1;
        scan_next     = ra_o;
        row_next      = row_q;
        row_base_next = row_base_q;
        ma_next       = ma_o + 14'd1;
        vs_left_next  = vs_left_q;
        if (line_end) begin
            scan_next = ra_o + 5'd1;
            if (row_end) begin
                scan_next     = '0;
                row_next      = row_q + 8'd1;
                row_base_next = row_base_q + {6'd0, hdisp_i};
                if (frame_end) begin
                    row_next      = '0;
                    row_base_next = start_addr_i;
                end
            end
            ma_next = row_base_next;
            // vsync counts whole scanlines from the first line of the sync row.
            if (scan_next == '0 && row_next == vsync_pos_i) begin
                vs_left_next = vsync_width_i;
            end else if (vs_left_q != '0) begin
                vs_left_next = vs_left_q - 4'd1;
            end
        end
    end

    assign hs_end    = {1'b0, hsync_pos_i} + {5'd0, hsync_width_i};
    assign hsync_now = (col_q >= hsync_pos_i) && ({1'b0, col_q} < hs_end);

    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            col_q      <= '0;
            row_q      <= '0;
            ra_o       <= '0;
            ma_o       <= '0;
            row_base_q <= '0;
            vs_left_q  <= '0;
            hsync_o    <= 1'b0;
            vsync_o    <= 1'b0;
            de_o       <= 1'b0;
        end else if (char_en_i) begin
            col_q      <= col_next;
            row_q      <= row_next;
            ra_o       <= scan_next;
            ma_o       <= ma_next;
            row_base_q <= row_base_next;
            vs_left_q  <= vs_left_next;
            // syncs of the cell just fetched, so they line up with its pixels.
            hsync_o    <= hsync_now;
            vsync_o    <= (vs_left_q != '0);
            // de of the cell about to be fetched; the shifter holds it one more cell.
            de_o       <= (col_next < hdisp_i) && (row_next < vdisp_i);
        end
    end

    // the fetch unit relies on ma holding still for the whole character cycle.
    ma_stable_a: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        !$past(char_en_i) |-> $stable(ma_o));

endmodule

`default_nettype wire

//--- rtl/video_phase_gen.sv
`default_nettype none
`timescale 1ns/1ps

module video_phase_gen
    import pet_video_pkg::*;
(
    input  wire logic clk16_i,
    input  wire logic rst_n_i,
    output fetch_slot_e slot_o,
    output logic      char_en_o,
    output logic      latch_char_o,
    output logic      latch_glyph_o,
    output logic      pixel_en_o
);

    phase_t phase_q;
    logic   run_q;

    // run_q keeps the bus idle until the first full character cycle.
    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= '0;
            run_q   <= 1'b0;
        end else begin
            phase_q <= phase_q + 4'd1;
            if (char_en_o) begin
                run_q <= 1'b1;
            end
        end
    end

    assign char_en_o     = (phase_q == 4'd15);
    assign latch_char_o  = (phase_q == 4'd3);
    assign latch_glyph_o = (phase_q == 4'd7);
    // two clocks per pixel at 8 MHz.
    assign pixel_en_o    = phase_q[0];

    // phases 0-3 read video ram, 4-7 read the character rom.
    always_comb begin
        case (phase_q[3:2])
            2'd0:    slot_o = run_q ? SLOT_VRAM : SLOT_IDLE;
            2'd1:    slot_o = run_q ? SLOT_VROM : SLOT_IDLE;
            default: slot_o = SLOT_IDLE;
        endcase
    end

    char_en_period_a: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        char_en_o |=> !char_en_o [*15] ##1 char_en_o);

endmodule

`default_nettype wire

//--- rtl/char_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module char_fetch
    import pet_video_pkg::*;
#(
    parameter logic [1:0] CHROM_BASE = 2'b10
) (
    input  wire logic        clk16_i,
    input  wire logic        rst_n_i,
    input  wire fetch_slot_e slot_i,
    input  wire logic        latch_char_i,
    input  wire logic        latch_glyph_i,
    input  wire mem_addr_t   ma_i,
    input  wire row_addr_t   ra_i,
    input  wire byte_t       data_i,
    output bus_addr_t        addr_o,
    output logic             addr_oe_o,
    output byte_t            glyph_o,
    output logic             reverse_o,
    output logic             row_valid_o
);

    logic [6:0] code_q;
    logic       rev_q;

    // rom address is base, pad, glyph index, then the scanline within it.
    always_comb begin
        case (slot_i)
            SLOT_VRAM: addr_o = ma_i;
            SLOT_VROM: addr_o = {CHROM_BASE, 2'b00, code_q, ra_i[2:0]};
            default:   addr_o = '0;
        endcase
    end

    assign addr_oe_o = (slot_i != SLOT_IDLE);

    // bit 7 of the screen code selects reverse video.
    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rev_q <= 1'b0;
        end else if (latch_char_i) begin
            rev_q <= data_i[7];
        end
    end

    always_ff @(posedge clk16_i) begin
        if (latch_char_i) begin
            code_q <= data_i[6:0];
        end
        if (latch_glyph_i) begin
            glyph_o <= data_i;
        end
    end

    assign reverse_o = rev_q;

    // the rom holds 8 lines per glyph; taller rows are blank below that.
    assign row_valid_o = (ra_i[4:3] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/dot_shifter.sv
`default_nettype none
`timescale 1ns/1ps

module dot_shifter
    import pet_video_pkg::*;
(
    input  wire logic  clk16_i,
    input  wire logic  rst_n_i,
    input  wire logic  load_i,
    input  wire logic  pixel_en_i,
    input  wire byte_t glyph_i,
    input  wire logic  reverse_i,
    input  wire logic  row_valid_i,
    input  wire logic  de_i,
    output logic       video_o
);

    byte_t shift_q;
    logic  rev_q;
    logic  blank_q;

    // attributes are taken on the same load as the glyph they belong to.
    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rev_q   <= 1'b0;
            blank_q <= 1'b1;
        end else if (load_i) begin
            rev_q   <= reverse_i;
            blank_q <= !de_i || !row_valid_i;
        end
    end

    // msb is the leftmost pixel.
    always_ff @(posedge clk16_i) begin
        if (load_i) begin
            shift_q <= glyph_i;
        end else if (pixel_en_i) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    assign video_o = blank_q ? 1'b0 : (shift_q[7] ^ rev_q);

endmodule

`default_nettype wire

//--- rtl/pet_video_top.sv
`default_nettype none
`timescale 1ns/1ps

module pet_video_top
    import pet_video_pkg::*;
#(
    parameter logic [1:0] CHROM_BASE = 2'b10
) (
    input  wire logic  clk16_i,
    input  wire logic  rst_n_i,
    input  wire logic  crtc_cs_i,
    input  wire logic  rw_n_i,
    input  wire logic  rs_i,
    input  wire byte_t data_i,
    output bus_addr_t  addr_o,
    output logic       addr_oe_o,
    output logic       h_sync_o,
    output logic       v_sync_o,
    output logic       video_o
);

    char_cnt_t   htotal, hdisp, hsync_pos;
    char_cnt_t   vtotal, vdisp, vsync_pos;
    logic [3:0]  hsync_width, vsync_width;
    row_addr_t   max_scan;
    mem_addr_t   start_addr;
    mem_addr_t   ma;
    row_addr_t   ra;
    logic        hsync, vsync, de;
    fetch_slot_e slot;
    logic        char_en, latch_char, latch_glyph, pixel_en;
    byte_t       glyph;
    logic        reverse, row_valid;

    crtc_regs u_regs (
        .clk16_i(clk16_i), .rst_n_i(rst_n_i),
        .cs_i(crtc_cs_i), .rw_n_i(rw_n_i), .rs_i(rs_i), .data_i(data_i),
        .htotal_o(htotal), .hdisp_o(hdisp), .hsync_pos_o(hsync_pos),
        .vtotal_o(vtotal), .vdisp_o(vdisp), .vsync_pos_o(vsync_pos),
        .hsync_width_o(hsync_width), .vsync_width_o(vsync_width),
        .max_scan_o(max_scan), .start_addr_o(start_addr)
    );

    crtc_timing u_timing (
        .clk16_i(clk16_i), .rst_n_i(rst_n_i), .char_en_i(char_en),
        .htotal_i(htotal), .hdisp_i(hdisp), .hsync_pos_i(hsync_pos),
        .vtotal_i(vtotal), .vdisp_i(vdisp), .vsync_pos_i(vsync_pos),
        .hsync_width_i(hsync_width), .vsync_width_i(vsync_width),
        .max_scan_i(max_scan), .start_addr_i(start_addr),
        .ma_o(ma), .ra_o(ra), .hsync_o(hsync), .vsync_o(vsync), .de_o(de)
    );

    video_phase_gen u_phase (
        .clk16_i(clk16_i), .rst_n_i(rst_n_i), .slot_o(slot),
        .char_en_o(char_en), .latch_char_o(latch_char),
        .latch_glyph_o(latch_glyph), .pixel_en_o(pixel_en)
    );

    char_fetch #(
        .CHROM_BASE(CHROM_BASE)
    ) u_fetch (
        .clk16_i(clk16_i), .rst_n_i(rst_n_i), .slot_i(slot),
        .latch_char_i(latch_char), .latch_glyph_i(latch_glyph),
        .ma_i(ma), .ra_i(ra), .data_i(data_i),
        .addr_o(addr_o), .addr_oe_o(addr_oe_o),
        .glyph_o(glyph), .reverse_o(reverse), .row_valid_o(row_valid)
    );

    dot_shifter u_shifter (
        .clk16_i(clk16_i), .rst_n_i(rst_n_i),
        .load_i(char_en), .pixel_en_i(pixel_en), .glyph_i(glyph),
        .reverse_i(reverse), .row_valid_i(row_valid), .de_i(de),
        .video_o(video_o)
    );

    // monitor expects negative syncs.
    assign h_sync_o = !hsync;
    assign v_sync_o = !vsync;

endmodule

`default_nettype wire

//--- verif/pet_video_tb.sv
`default_nettype none
`timescale 1ns/1ps

module pet_video_tb
    import pet_video_pkg::*;
();

    localparam logic [1:0] CHROM_BASE = 2'b10;
    // four frames of 14 characters by 60 scanlines, plus half again.
    localparam int CYCLE_LIMIT = 3 * 4 * 16 * 14 * 60 / 2;

    logic      clk16_i;
    logic      rst_n_i;
    logic      crtc_cs_i;
    logic      rw_n_i;
    logic      rs_i;
    byte_t     cpu_data;
    byte_t     data_i;
    bus_addr_t addr_o;
    logic      addr_oe_o;
    logic      h_sync_o;
    logic      v_sync_o;
    logic      video_o;

    byte_t     vram_tab [1024];
    int        errors;
    int        cycle_cnt;
    phase_t    phase;
    logic      booted;

    // register contents as last written by the cpu.
    char_cnt_t cfg_htotal, cfg_hdisp, cfg_hpos;
    char_cnt_t cfg_vtotal, cfg_vdisp, cfg_vpos;
    logic [3:0] cfg_hsw;
    row_addr_t cfg_max_scan;
    mem_addr_t cfg_start;

    // screen position of the cell being fetched, and what it should produce.
    char_cnt_t col, row;
    row_addr_t scan;
    logic      armed, chk_en, cell_disp;
    mem_addr_t exp_ma;
    bus_addr_t exp_rom;
    byte_t     code, vid_glyph;
    logic      vid_rev, vid_blank, vid_valid, exp_pix;
    logic      hs_last, vs_last, hs_fell, hs_rose, vs_fell;
    logic      hs_seen, hs_dirty, hs_period_ok;
    int        hs_low_cnt, hs_width, hs_per_cnt, hs_period;

    pet_video_top #(
        .CHROM_BASE(CHROM_BASE)
    ) DUT (
        .clk16_i(clk16_i), .rst_n_i(rst_n_i),
        .crtc_cs_i(crtc_cs_i), .rw_n_i(rw_n_i), .rs_i(rs_i), .data_i(data_i),
        .addr_o(addr_o), .addr_oe_o(addr_oe_o),
        .h_sync_o(h_sync_o), .v_sync_o(v_sync_o), .video_o(video_o)
    );

    // character rom contents are a hash of screen code and glyph line.
    function automatic byte_t rom_glyph(input logic [6:0] chr, input logic [2:0] line);
        return byte_t'(chr * 8'd29) ^ {line, line, line[1:0]} ^ 8'h5a;
    endfunction

    function automatic byte_t bus_read(input bus_addr_t a);
        if (a[13:12] == CHROM_BASE) begin
            return rom_glyph(a[9:3], a[2:0]);
        end
        return vram_tab[a[9:0]] ^ {4'h0, a[13:10]};
    endfunction

    // memories answer while the bus is driven and the cpu owns data_i otherwise.
    assign data_i = addr_oe_o ? bus_read(addr_o) : cpu_data;

    initial begin
        clk16_i = 1'b0;
        forever #50 clk16_i = ~clk16_i;
    end

    always_ff @(posedge clk16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase  <= '0;
            booted <= 1'b0;
        end else begin
            phase <= phase + 4'd1;
            if (phase == 4'd15) begin
                booted <= 1'b1;
            end
        end
    end

    always @(posedge clk16_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout: frames did not complete within %0d clocks, %0d errors",
            CYCLE_LIMIT, errors);
        $display("TB FAILED");
        $finish;
    end

    // the cell fetched in the last cycle is the one shown in this cycle.
    task automatic advance_cell();
        vid_valid = chk_en;
        vid_blank = !cell_disp || (scan >= 5'd8);
        vid_glyph = rom_glyph(code[6:0], scan[2:0]);
        vid_rev   = code[7];
        if (col >= cfg_htotal) begin
            col = '0;
            if (scan >= cfg_max_scan) begin
                scan = '0;
                row  = (row >= cfg_vtotal) ? 8'd0 : row + 8'd1;
            end else begin
                scan = scan + 5'd1;
            end
        end else begin
            col = col + 8'd1;
        end
        // syncs trail the fetch by one cell.
        if (hs_fell) begin
            col = cfg_hpos + 8'd1;
        end
        if (vs_fell) begin
            row  = cfg_vpos;
            scan = '0;
            col  = 8'd1;
            if (armed) begin
                chk_en = 1'b1;
            end
        end
        cell_disp = (col < cfg_hdisp) && (row < cfg_vdisp);
        exp_ma    = cfg_start + mem_addr_t'(row) * mem_addr_t'(cfg_hdisp) + mem_addr_t'(col);
    endtask

    always @(negedge clk16_i) begin
        hs_fell = hs_last && !h_sync_o;
        hs_rose = !hs_last && h_sync_o;
        vs_fell = vs_last && !v_sync_o;
        hs_last = h_sync_o;
        vs_last = v_sync_o;
        if (hs_rose) begin
            hs_width = hs_low_cnt;
        end
        hs_low_cnt = h_sync_o ? 0 : hs_low_cnt + 1;
        if (hs_fell) begin
            hs_period    = hs_per_cnt;
            hs_period_ok = hs_seen && !hs_dirty;
            hs_seen      = 1'b1;
            hs_dirty     = 1'b0;
            hs_per_cnt   = 1;
        end else begin
            hs_per_cnt = hs_per_cnt + 1;
        end
        if (booted && phase == 4'd0) begin
            advance_cell();
        end
        if (phase == 4'd3) begin
            code    = data_i;
            exp_rom = {CHROM_BASE, 2'b00, code[6:0], scan[2:0]};
        end
        exp_pix = vid_blank ? 1'b0 : (vid_glyph[3'd7 - phase[3:1]] ^ vid_rev);
    end

    // one cpu bus write placed in an idle bus phase.
    task automatic cpu_write(input logic sel, input byte_t val);
        @(negedge clk16_i);
        while (phase != 4'd8) begin
            @(negedge clk16_i);
        end
        crtc_cs_i = 1'b1;
        rw_n_i    = 1'b0;
        rs_i      = sel;
        cpu_data  = val;
        @(negedge clk16_i);
        crtc_cs_i = 1'b0;
        rw_n_i    = 1'b1;
    endtask

    task automatic reg_write(input reg_idx_t idx, input byte_t val);
        cpu_write(1'b0, byte_t'(idx));
        cpu_write(1'b1, val);
        case (idx)
            R_HTOTAL:     cfg_htotal = val;
            R_HDISP:      cfg_hdisp = val;
            R_HSYNC_POS:  cfg_hpos = val;
            R_SYNC_WIDTH: cfg_hsw = val[3:0];
            R_VTOTAL:     cfg_vtotal = val;
            R_VDISP:      cfg_vdisp = val;
            R_VSYNC_POS:  cfg_vpos = val;
            R_MAX_SCAN:   cfg_max_scan = val[4:0];
            R_START_HI:   cfg_start[13:8] = val[5:0];
            R_START_LO:   cfg_start[7:0] = val;
            default: ;
        endcase
        hs_dirty = 1'b1;
    endtask

    initial begin
        rst_n_i   = 1'b0;
        crtc_cs_i = 1'b0;
        rw_n_i    = 1'b1;
        rs_i      = 1'b0;
        cpu_data  = '0;
        errors    = 0;
        cycle_cnt = 0;
        {cfg_htotal, cfg_hdisp, cfg_hpos, cfg_vtotal, cfg_vdisp, cfg_vpos} = '0;
        {cfg_hsw, cfg_max_scan, cfg_start} = '0;
        {col, row, scan} = '0;
        {armed, chk_en, cell_disp, vid_valid, vid_blank, vid_rev} = '0;
        {hs_seen, hs_dirty, hs_period_ok, hs_fell, hs_rose, vs_fell} = '0;
        hs_last    = 1'b1;
        vs_last    = 1'b1;
        hs_low_cnt = 0;
        hs_per_cnt = 0;
        void'($urandom(14916));
        for (int i = 0; i < 1024; i++) begin
            vram_tab[i] = byte_t'($urandom);
        end
        repeat (10) @(negedge clk16_i);
        rst_n_i = 1'b1;
        // small frame of 12 characters by 6 rows of 10 scanlines.
        reg_write(R_HTOTAL, 8'd11);
        reg_write(R_HDISP, 8'd8);
        reg_write(R_HSYNC_POS, 8'd9);
        reg_write(R_SYNC_WIDTH, 8'h21);
        reg_write(R_VTOTAL, 8'd5);
        reg_write(R_VDISP, 8'd4);
        reg_write(R_VSYNC_POS, 8'd4);
        reg_write(R_MAX_SCAN, 8'd9);
        reg_write(R_START_HI, 8'h00);
        reg_write(R_START_LO, 8'h20);
        armed = 1'b1;
        @(negedge v_sync_o);
        repeat (2) @(negedge v_sync_o);
        // written during the vsync rows, so the next frame starts clean.
        reg_write(R_HTOTAL, 8'd13);
        reg_write(R_START_HI, 8'h00);
        reg_write(R_START_LO, 8'h40);
        repeat (2) @(negedge v_sync_o);
        $display("pet_video_tb finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    reset_idle_a: assert property (@(posedge clk16_i)
        !booted |-> h_sync_o && v_sync_o && !video_o && !addr_oe_o)
        else begin
            errors = errors + 1;
            $write("** Error %0t: h_sync_o/v_sync_o/video_o/addr_oe_o", $time);
            $display(" expected 1/1/0/0, got %b/%b/%b/%b", $sampled(h_sync_o),
                $sampled(v_sync_o), $sampled(video_o), $sampled(addr_oe_o));
        end

    oe_slot_a: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        booted |-> addr_oe_o == (phase < 4'd8))
        else begin
            errors = errors + 1;
            $display("** Error %0t: addr_oe_o expected %b, got %b",
                $time, $sampled(phase) < 4'd8, $sampled(addr_oe_o));
        end

    hs_width_a: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        chk_en && hs_rose |-> hs_width == 16 * int'(cfg_hsw))
        else begin
            errors = errors + 1;
            $display("** Error %0t: h_sync_o low clocks expected %0d, got %0d",
                $time, 16 * int'($sampled(cfg_hsw)), $sampled(hs_width));
        end

    hs_period_a: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        chk_en && hs_fell && hs_period_ok |-> hs_period == 16 * (int'(cfg_htotal) + 1))
        else begin
            errors = errors + 1;
            $display("** Error %0t: h_sync_o period expected %0d, got %0d",
                $time, 16 * (int'($sampled(cfg_htotal)) + 1), $sampled(hs_period));
        end

    vram_addr_a: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        chk_en && phase < 4'd4 && cell_disp |-> addr_o == exp_ma)
        else begin
            errors = errors + 1;
            $display("** Error %0t: addr_o (vram) expected %h, got %h",
                $time, $sampled(exp_ma), $sampled(addr_o));
        end

    rom_addr_a: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        chk_en && phase >= 4'd4 && phase < 4'd8 |-> addr_o == exp_rom)
        else begin
            errors = errors + 1;
            $display("** Error %0t: addr_o (rom) expected %h, got %h",
                $time, $sampled(exp_rom), $sampled(addr_o));
        end

    // covers both the glyph pixels and blanking outside the text area.
    video_a: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        vid_valid |-> video_o == exp_pix)
        else begin
            errors = errors + 1;
            $display("** Error %0t: video_o expected %b, got %b",
                $time, $sampled(exp_pix), $sampled(video_o));
        end

endmodule

`default_nettype wire

//--- pet_video.f
common/pet_video_pkg.sv
crtc/crtc_regs.sv
crtc/crtc_timing.sv
rtl/video_phase_gen.sv
rtl/char_fetch.sv
rtl/dot_shifter.sv
rtl/pet_video_top.sv
verif/pet_video_tb.sv

//--- Bender.yml
package:
  name: pet_video

sources:
  - common/pet_video_pkg.sv
  - crtc/crtc_regs.sv
  - crtc/crtc_timing.sv
  - rtl/video_phase_gen.sv
  - rtl/char_fetch.sv
  - rtl/dot_shifter.sv
  - rtl/pet_video_top.sv
  - target: test
    files:
      - verif/pet_video_tb.sv
